//--- Makefile
TOP := tb_axi_rd_ic

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f axi_rd_ic.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir

//--- ar_arbiter.sv
`timescale 1ns/1ps

module ar_arbiter (
    input  logic clk,
    input  logic rst,
    input  logic m0_ar_valid,
    input  logic m1_ar_valid,
    input  logic sel_ready,
    input  logic s0_r_valid,
    input  logic s1_r_valid,
    input  logic r_last,
    input  logic r_handshake,
    output logic grant_m0,
    output logic grant_m1,
    output logic m0_ar_ready,
    output logic m1_ar_ready,
    output logic r_owner_s1,
    output logic r_owner_valid
);

    logic lock_m0;
    logic lock_m1;
    logic r_lock;
    logic r_lock_s1;

    // Master 1 first, unless master 0 is already waiting on the slave
    assign grant_m1 = (m1_ar_valid & ~lock_m0) | lock_m1;
    assign grant_m0 = ~grant_m1 & (m0_ar_valid | lock_m0);

    assign m0_ar_ready = grant_m0 & m0_ar_valid & sel_ready;
    assign m1_ar_ready = grant_m1 & m1_ar_valid & sel_ready;

    // A lock stays set while the granted address is stalled
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lock_m0 <= 1'b0;
            lock_m1 <= 1'b0;
        end else begin
            lock_m0 <= grant_m0 & m0_ar_valid & ~sel_ready;
            lock_m1 <= grant_m1 & m1_ar_valid & ~sel_ready;
        end
    end

    // R owner, slave 1 wins when the channel is free
    assign r_owner_valid = r_lock | s0_r_valid | s1_r_valid;
    assign r_owner_s1    = r_lock ? r_lock_s1 : s1_r_valid;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            r_lock    <= 1'b0;
            r_lock_s1 <= 1'b0;
        end else if (r_handshake & r_last) begin
            r_lock <= 1'b0;                  // Burst finished
        end else if (r_owner_valid & ~r_lock) begin
            r_lock    <= 1'b1;
            r_lock_s1 <= r_owner_s1;
        end
    end

endmodule

//--- ar_decoder.sv
`timescale 1ns/1ps

module ar_decoder (
    input  ic_map_pkg::ids_t               sel_id,
    input  logic [axi_pkg::ADDR_BITS-1:0]  sel_addr,
    input  logic [axi_pkg::LEN_BITS-1:0]   sel_len,
    input  logic [axi_pkg::SIZE_BITS-1:0]  sel_size,
    input  logic [axi_pkg::BURST_BITS-1:0] sel_burst,
    input  logic                           sel_valid,
    output ic_map_pkg::ids_t               s0_ar_id,
    output logic [axi_pkg::ADDR_BITS-1:0]  s0_ar_addr,
    output logic [axi_pkg::LEN_BITS-1:0]   s0_ar_len,
    output logic [axi_pkg::SIZE_BITS-1:0]  s0_ar_size,
    output logic [axi_pkg::BURST_BITS-1:0] s0_ar_burst,
    output logic                           s0_ar_valid,
    input  logic                           s0_ar_ready,
    output ic_map_pkg::ids_t               s1_ar_id,
    output logic [axi_pkg::ADDR_BITS-1:0]  s1_ar_addr,
    output logic [axi_pkg::LEN_BITS-1:0]   s1_ar_len,
    output logic [axi_pkg::SIZE_BITS-1:0]  s1_ar_size,
    output logic [axi_pkg::BURST_BITS-1:0] s1_ar_burst,
    output logic                           s1_ar_valid,
    input  logic                           s1_ar_ready,
    output logic                           sel_ready
);

    import axi_pkg::*;
    import ic_map_pkg::*;

    logic to_s1;

    assign to_s1 = |sel_addr[ADDR_BITS-1:REGION_LSB];   // Any nonzero region

    // Both slaves see the fields, only one sees valid
    assign s0_ar_id    = sel_id;
    assign s0_ar_addr  = sel_addr;
    assign s0_ar_len   = sel_len;
    assign s0_ar_size  = sel_size;
    assign s0_ar_burst = sel_burst;
    assign s0_ar_valid = sel_valid & ~to_s1;

    assign s1_ar_id    = sel_id;
    assign s1_ar_addr  = sel_addr;
    assign s1_ar_len   = sel_len;
    assign s1_ar_size  = sel_size;
    assign s1_ar_burst = sel_burst;
    assign s1_ar_valid = sel_valid & to_s1;

    assign sel_ready = to_s1 ? s1_ar_ready : s0_ar_ready;

endmodule

//--- ar_mux.sv
`timescale 1ns/1ps

module ar_mux (
    input  logic                           grant_m0,
    input  logic                           grant_m1,
    input  logic [axi_pkg::ID_BITS-1:0]    m0_ar_id,
    input  logic [axi_pkg::ADDR_BITS-1:0]  m0_ar_addr,
    input  logic [axi_pkg::LEN_BITS-1:0]   m0_ar_len,
    input  logic [axi_pkg::SIZE_BITS-1:0]  m0_ar_size,
    input  logic [axi_pkg::BURST_BITS-1:0] m0_ar_burst,
    input  logic                           m0_ar_valid,
    input  logic [axi_pkg::ID_BITS-1:0]    m1_ar_id,
    input  logic [axi_pkg::ADDR_BITS-1:0]  m1_ar_addr,
    input  logic [axi_pkg::LEN_BITS-1:0]   m1_ar_len,
    input  logic [axi_pkg::SIZE_BITS-1:0]  m1_ar_size,
    input  logic [axi_pkg::BURST_BITS-1:0] m1_ar_burst,
    input  logic                           m1_ar_valid,
    output ic_map_pkg::ids_t               sel_id,
    output logic [axi_pkg::ADDR_BITS-1:0]  sel_addr,
    output logic [axi_pkg::LEN_BITS-1:0]   sel_len,
    output logic [axi_pkg::SIZE_BITS-1:0]  sel_size,
    output logic [axi_pkg::BURST_BITS-1:0] sel_burst,
    output logic                           sel_valid
);

    import ic_map_pkg::*;

    always_comb begin
        sel_id    = '0;
        sel_addr  = '0;
        sel_len   = '0;
        sel_size  = '0;
        sel_burst = '0;
        sel_valid = 1'b0;
        case ({grant_m1, grant_m0})
            2'b10: begin
                sel_id.fld.tag = TAG_M1;
                sel_id.fld.id  = m1_ar_id;
                sel_addr       = m1_ar_addr;
                sel_len        = m1_ar_len;
                sel_size       = m1_ar_size;
                sel_burst      = m1_ar_burst;
                sel_valid      = m1_ar_valid;
            end
            2'b01: begin
                sel_id.fld.tag = TAG_M0;
                sel_id.fld.id  = m0_ar_id;
                sel_addr       = m0_ar_addr;
                sel_len        = m0_ar_len;
                sel_size       = m0_ar_size;
                sel_burst      = m0_ar_burst;
                sel_valid      = m0_ar_valid;
            end
            default: sel_valid = 1'b0;       // Idle
        endcase
    end

endmodule

//--- axi_pkg.sv
package axi_pkg;

    // Master and slave ID widths differ by the tag the interconnect prepends
    localparam int ID_BITS   = 4;
    localparam int IDS_BITS  = 8;

    localparam int ADDR_BITS = 32;
    localparam int LEN_BITS  = 4;   // Beats minus one
    localparam int SIZE_BITS = 3;
    localparam int DATA_BITS = 32;

    localparam int BURST_BITS = 2;
    localparam int RESP_BITS  = 2;

    // Burst type
    localparam logic [BURST_BITS-1:0] BURST_INCR = 2'b01;

    // Read response
    localparam logic [RESP_BITS-1:0] RESP_OKAY = 2'b00;

endpackage

//--- axi_rd_ic.f
axi_pkg.sv
ic_map_pkg.sv
ar_arbiter.sv
ar_mux.sv
ar_decoder.sv
r_router.sv
axi_rd_ic.sv
axi_rd_ic_props.sv
tb_axi_rd_ic.sv

//--- axi_rd_ic.sv
`timescale 1ns/1ps

module axi_rd_ic (
    input  logic                           clk,
    input  logic                           rst,
    // Master 0
    input  logic [axi_pkg::ID_BITS-1:0]    m0_ar_id,
    input  logic [axi_pkg::ADDR_BITS-1:0]  m0_ar_addr,
    input  logic [axi_pkg::LEN_BITS-1:0]   m0_ar_len,
    input  logic [axi_pkg::SIZE_BITS-1:0]  m0_ar_size,
    input  logic [axi_pkg::BURST_BITS-1:0] m0_ar_burst,
    input  logic                           m0_ar_valid,
    output logic                           m0_ar_ready,
    output logic [axi_pkg::ID_BITS-1:0]    m0_r_id,
    output logic [axi_pkg::DATA_BITS-1:0]  m0_r_data,
    output logic [axi_pkg::RESP_BITS-1:0]  m0_r_resp,
    output logic                           m0_r_last,
    output logic                           m0_r_valid,
    input  logic                           m0_r_ready,
    // Master 1
    input  logic [axi_pkg::ID_BITS-1:0]    m1_ar_id,
    input  logic [axi_pkg::ADDR_BITS-1:0]  m1_ar_addr,
    input  logic [axi_pkg::LEN_BITS-1:0]   m1_ar_len,
    input  logic [axi_pkg::SIZE_BITS-1:0]  m1_ar_size,
    input  logic [axi_pkg::BURST_BITS-1:0] m1_ar_burst,
    input  logic                           m1_ar_valid,
    output logic                           m1_ar_ready,
    output logic [axi_pkg::ID_BITS-1:0]    m1_r_id,
    output logic [axi_pkg::DATA_BITS-1:0]  m1_r_data,
    output logic [axi_pkg::RESP_BITS-1:0]  m1_r_resp,
    output logic                           m1_r_last,
    output logic                           m1_r_valid,
    input  logic                           m1_r_ready,
    // Slave 0
    output ic_map_pkg::ids_t               s0_ar_id,
    output logic [axi_pkg::ADDR_BITS-1:0]  s0_ar_addr,
    output logic [axi_pkg::LEN_BITS-1:0]   s0_ar_len,
    output logic [axi_pkg::SIZE_BITS-1:0]  s0_ar_size,
    output logic [axi_pkg::BURST_BITS-1:0] s0_ar_burst,
    output logic                           s0_ar_valid,
    input  logic                           s0_ar_ready,
    input  ic_map_pkg::ids_t               s0_r_id,
    input  logic [axi_pkg::DATA_BITS-1:0]  s0_r_data,
    input  logic [axi_pkg::RESP_BITS-1:0]  s0_r_resp,
    input  logic                           s0_r_last,
    input  logic                           s0_r_valid,
    output logic                           s0_r_ready,
    // Slave 1
    output ic_map_pkg::ids_t               s1_ar_id,
    output logic [axi_pkg::ADDR_BITS-1:0]  s1_ar_addr,
    output logic [axi_pkg::LEN_BITS-1:0]   s1_ar_len,
    output logic [axi_pkg::SIZE_BITS-1:0]  s1_ar_size,
    output logic [axi_pkg::BURST_BITS-1:0] s1_ar_burst,
    output logic                           s1_ar_valid,
    input  logic                           s1_ar_ready,
    input  ic_map_pkg::ids_t               s1_r_id,
    input  logic [axi_pkg::DATA_BITS-1:0]  s1_r_data,
    input  logic [axi_pkg::RESP_BITS-1:0]  s1_r_resp,
    input  logic                           s1_r_last,
    input  logic                           s1_r_valid,
    output logic                           s1_r_ready
);

    import axi_pkg::*;
    import ic_map_pkg::*;

    logic                  grant_m0;
    logic                  grant_m1;
    ids_t                  sel_id;       // Tagged request from the mux
    logic [ADDR_BITS-1:0]  sel_addr;
    logic [LEN_BITS-1:0]   sel_len;
    logic [SIZE_BITS-1:0]  sel_size;
    logic [BURST_BITS-1:0] sel_burst;
    logic                  sel_valid;
    logic                  sel_ready;
    logic                  r_owner_s1;
    logic                  r_owner_valid;
    logic                  r_last;
    logic                  r_handshake;

    // Port names line up with the top level and the internal nets
    ar_arbiter ar_arbiter_i (.*);

    ar_mux ar_mux_i (.*);

    ar_decoder ar_decoder_i (.*);

    r_router r_router_i (.*);

endmodule

//--- axi_rd_ic_props.sv
`timescale 1ns/1ps

module axi_rd_ic_props (
    input logic clk,
    input logic rst,
    input logic m0_ar_valid,
    input logic m0_ar_ready,
    input logic m1_ar_valid,
    input logic m1_ar_ready,
    input logic m0_r_valid,
    input logic m1_r_valid,
    input logic s0_ar_valid,
    input logic s1_ar_valid
);

    // Address ready only answers a live request
    m0_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst)
        m0_ar_ready |-> m0_ar_valid)
        else $error("m0_ar_ready high without m0_ar_valid");

    m1_ready_needs_valid: assert property (@(posedge clk) disable iff (!rst)
        m1_ar_ready |-> m1_ar_valid)
        else $error("m1_ar_ready high without m1_ar_valid");

    one_master_r_valid: assert property (@(posedge clk) disable iff (!rst)
        !(m0_r_valid && m1_r_valid))
        else $error("r_valid high at both masters");

    // Decoder picks exactly one slave
    one_slave_ar_valid: assert property (@(posedge clk) disable iff (!rst)
        !(s0_ar_valid && s1_ar_valid))
        else $error("ar_valid high at both slaves");

endmodule

//--- ic_map_pkg.sv
package ic_map_pkg;

    import axi_pkg::*;

    localparam int TAG_BITS = IDS_BITS - ID_BITS;

    // Master tags in the upper ID bits seen by the slaves
    localparam logic [TAG_BITS-1:0] TAG_M0 = 4'b0001;
    localparam logic [TAG_BITS-1:0] TAG_M1 = 4'b0010;

    // Address bits above this one select the slave
    localparam int REGION_LSB = 16;

    typedef struct packed {
        logic [TAG_BITS-1:0] tag;
        logic [ID_BITS-1:0]  id;
    } ids_fields_t;

    // Slave-side ID, either a plain word or tag plus master ID
    typedef union packed {
        logic [IDS_BITS-1:0] flat;
        ids_fields_t         fld;
    } ids_t;

endpackage

//--- r_router.sv
`timescale 1ns/1ps

module r_router (
    input  logic                          r_owner_s1,
    input  logic                          r_owner_valid,
    input  ic_map_pkg::ids_t              s0_r_id,
    input  logic [axi_pkg::DATA_BITS-1:0] s0_r_data,
    input  logic [axi_pkg::RESP_BITS-1:0] s0_r_resp,
    input  logic                          s0_r_last,
    input  logic                          s0_r_valid,
    output logic                          s0_r_ready,
    input  ic_map_pkg::ids_t              s1_r_id,
    input  logic [axi_pkg::DATA_BITS-1:0] s1_r_data,
    input  logic [axi_pkg::RESP_BITS-1:0] s1_r_resp,
    input  logic                          s1_r_last,
    input  logic                          s1_r_valid,
    output logic                          s1_r_ready,
    output logic [axi_pkg::ID_BITS-1:0]   m0_r_id,
    output logic [axi_pkg::DATA_BITS-1:0] m0_r_data,
    output logic [axi_pkg::RESP_BITS-1:0] m0_r_resp,
    output logic                          m0_r_last,
    output logic                          m0_r_valid,
    input  logic                          m0_r_ready,
    output logic [axi_pkg::ID_BITS-1:0]   m1_r_id,
    output logic [axi_pkg::DATA_BITS-1:0] m1_r_data,
    output logic [axi_pkg::RESP_BITS-1:0] m1_r_resp,
    output logic                          m1_r_last,
    output logic                          m1_r_valid,
    input  logic                          m1_r_ready,
    output logic                          r_last,
    output logic                          r_handshake
);

    import axi_pkg::*;
    import ic_map_pkg::*;

    ids_t                 beat_id;
    logic [DATA_BITS-1:0] beat_data;
    logic [RESP_BITS-1:0] beat_resp;
    logic                 beat_valid;
    logic                 beat_ready;
    logic                 to_m0;
    logic                 to_m1;

    // Beat of the owning slave
    assign beat_id    = r_owner_s1 ? s1_r_id   : s0_r_id;
    assign beat_data  = r_owner_s1 ? s1_r_data : s0_r_data;
    assign beat_resp  = r_owner_s1 ? s1_r_resp : s0_r_resp;
    assign r_last     = r_owner_s1 ? s1_r_last : s0_r_last;
    assign beat_valid = r_owner_valid & (r_owner_s1 ? s1_r_valid : s0_r_valid);

    assign to_m0 = (beat_id.fld.tag == TAG_M0);
    assign to_m1 = (beat_id.fld.tag == TAG_M1);

    assign m0_r_id    = beat_id.fld.id;      // Tag stripped
    assign m0_r_data  = beat_data;
    assign m0_r_resp  = beat_resp;
    assign m0_r_last  = r_last;
    assign m0_r_valid = beat_valid & to_m0;

    assign m1_r_id    = beat_id.fld.id;
    assign m1_r_data  = beat_data;
    assign m1_r_resp  = beat_resp;
    assign m1_r_last  = r_last;
    assign m1_r_valid = beat_valid & to_m1;

    assign beat_ready = (to_m0 & m0_r_ready) | (to_m1 & m1_r_ready);

    // Ready goes back to the owner only
    assign s0_r_ready  = r_owner_valid & ~r_owner_s1 & beat_ready;
    assign s1_r_ready  = r_owner_valid & r_owner_s1 & beat_ready;
    assign r_handshake = beat_valid & beat_ready;

endmodule

//--- tb_axi_rd_ic.sv
`timescale 1ns/1ps

module tb_axi_rd_ic;

    import axi_pkg::*;
    import ic_map_pkg::*;

    typedef struct packed {
        logic [IDS_BITS-1:0]  id;
        logic [ADDR_BITS-1:0] addr;
        logic [LEN_BITS-1:0]  len;
    } burst_t;

    typedef struct {
        logic                 m0_v;
        logic [ID_BITS-1:0]   m0_id;
        logic [ADDR_BITS-1:0] m0_addr;
        logic [LEN_BITS-1:0]  m0_len;
        logic                 m1_v;
        logic [ID_BITS-1:0]   m1_id;
        logic [ADDR_BITS-1:0] m1_addr;
        logic [LEN_BITS-1:0]  m1_len;
        int                   m1_start;   // Cycle at which master 1 raises valid
        int                   s0_delay;
        int                   s1_delay;
        logic                 m0_to_s1;   // Expected slave for each master's address
        logic                 m1_to_s1;
    } row_t;

    localparam int NUM_ROWS = 6;
    localparam int MAX_DELAY = 8;
    localparam int LIMIT = 20 + NUM_ROWS * (MAX_DELAY + 2 * 16 * 16);

    logic clk = 1'b0;
    logic rst;
    logic [ID_BITS-1:0] m0_ar_id, m1_ar_id, m0_r_id, m1_r_id;
    logic [ADDR_BITS-1:0] m0_ar_addr, m1_ar_addr, s0_ar_addr, s1_ar_addr;
    logic [LEN_BITS-1:0] m0_ar_len, m1_ar_len, s0_ar_len, s1_ar_len;
    logic [SIZE_BITS-1:0] m0_ar_size, m1_ar_size, s0_ar_size, s1_ar_size;
    logic [BURST_BITS-1:0] m0_ar_burst, m1_ar_burst, s0_ar_burst, s1_ar_burst;
    logic m0_ar_valid, m1_ar_valid, m0_ar_ready, m1_ar_ready;
    logic [DATA_BITS-1:0] m0_r_data, m1_r_data, s0_r_data, s1_r_data;
    logic [RESP_BITS-1:0] m0_r_resp, m1_r_resp, s0_r_resp, s1_r_resp;
    logic m0_r_last, m1_r_last, m0_r_valid, m1_r_valid, m0_r_ready, m1_r_ready;
    ids_t s0_ar_id, s1_ar_id, s0_r_id, s1_r_id;
    logic s0_ar_valid, s1_ar_valid, s0_ar_ready, s1_ar_ready;
    logic s0_r_last, s1_r_last, s0_r_valid, s1_r_valid, s0_r_ready, s1_r_ready;

    row_t stim [NUM_ROWS];
    burst_t slave_q [2][$];
    logic [LEN_BITS-1:0] beat [2];
    logic rv [2];                 // Slave holds r_valid
    int wait_cnt [2];
    logic m0_act, m1_act, m1_todo, lock0, lock1, own_v, own;
    int cycle_cnt = 0;

    axi_rd_ic axi_rd_ic_i (.*);

    bind axi_rd_ic axi_rd_ic_props axi_rd_ic_props_i (.*);

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT)
            fail_run("Timeout: the tests did not finish within the cycle limit");
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            fail_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic row_t make_row(logic m0v, logic [3:0] m0i, logic [31:0] m0a,
                                      logic [3:0] m0l, logic m1v, logic [3:0] m1i,
                                      logic [31:0] m1a, logic [3:0] m1l, int m1s,
                                      int d0, int d1, logic m0t, logic m1t);
        row_t r;
        r.m0_v = m0v;
        r.m0_id = m0i;
        r.m0_addr = m0a;
        r.m0_len = m0l;
        r.m1_v = m1v;
        r.m1_id = m1i;
        r.m1_addr = m1a;
        r.m1_len = m1l;
        r.m1_start = m1s;
        r.s0_delay = d0;
        r.s1_delay = d1;
        r.m0_to_s1 = m0t;
        r.m1_to_s1 = m1t;
        return r;
    endfunction

    task automatic drive_inputs(input int r);
        logic [31:0] rnd;
        burst_t b;
        m0_ar_valid = m0_act;
        m0_ar_id = stim[r].m0_id;
        m0_ar_addr = stim[r].m0_addr;
        m0_ar_len = stim[r].m0_len;
        m1_ar_valid = m1_act;
        m1_ar_id = stim[r].m1_id;
        m1_ar_addr = stim[r].m1_addr;
        m1_ar_len = stim[r].m1_len;
        s0_ar_ready = (wait_cnt[0] >= stim[r].s0_delay);
        s1_ar_ready = (wait_cnt[1] >= stim[r].s1_delay);
        rnd = $urandom;
        m0_r_ready = rnd[0];
        m1_r_ready = rnd[1];
        for (int s = 0; s < 2; s++)
            if (!rv[s] && slave_q[s].size() > 0) rv[s] = rnd[2+s];
        s0_r_valid = rv[0];
        s0_r_id.flat = '0;        // Fields idle while valid is low
        s0_r_data = '0;
        s0_r_last = 1'b0;
        s0_r_resp = RESP_OKAY;
        if (rv[0]) begin
            b = slave_q[0][0];
            s0_r_id.flat = b.id;
            s0_r_data = b.addr + {28'd0, beat[0]};
            s0_r_last = (beat[0] == b.len);
        end
        s1_r_valid = rv[1];
        s1_r_id.flat = '0;
        s1_r_data = '0;
        s1_r_last = 1'b0;
        s1_r_resp = RESP_OKAY;
        if (rv[1]) begin
            b = slave_q[1][0];
            s1_r_id.flat = b.id;
            s1_r_data = b.addr + {28'd0, beat[1]};
            s1_r_last = (beat[1] == b.len);
        end
    endtask

    // Expected AR owner from the priority and lock rules
    task automatic check_ar(input int r);
        logic have, exp_m1, tgt, rdy;
        burst_t b;
        have = 1'b1;
        exp_m1 = 1'b0;
        if (lock0) exp_m1 = 1'b0;
        else if (lock1) exp_m1 = 1'b1;
        else if (m1_act) exp_m1 = 1'b1;
        else if (m0_act) exp_m1 = 1'b0;
        else have = 1'b0;
        if (!have) begin
            check_val("s0_ar_valid", 32'(s0_ar_valid), 32'd0);
            check_val("s1_ar_valid", 32'(s1_ar_valid), 32'd0);
            check_val("m0_ar_ready", 32'(m0_ar_ready), 32'd0);
            check_val("m1_ar_ready", 32'(m1_ar_ready), 32'd0);
        end else begin
            b.addr = exp_m1 ? stim[r].m1_addr : stim[r].m0_addr;
            b.len = exp_m1 ? stim[r].m1_len : stim[r].m0_len;
            b.id = exp_m1 ? {TAG_M1, stim[r].m1_id} : {TAG_M0, stim[r].m0_id};
            tgt = exp_m1 ? stim[r].m1_to_s1 : stim[r].m0_to_s1;
            check_val("s0_ar_valid", 32'(s0_ar_valid), 32'(!tgt));
            check_val("s1_ar_valid", 32'(s1_ar_valid), 32'(tgt));
            check_val("ar_addr", tgt ? s1_ar_addr : s0_ar_addr, b.addr);
            check_val("ar_id", 32'(tgt ? s1_ar_id.flat : s0_ar_id.flat), 32'(b.id));
            check_val("ar_len", 32'(tgt ? s1_ar_len : s0_ar_len), 32'(b.len));
            check_val("ar_size", 32'(tgt ? s1_ar_size : s0_ar_size), exp_m1 ? 32'd1 : 32'd2);
            check_val("ar_burst", 32'(tgt ? s1_ar_burst : s0_ar_burst), 32'(BURST_INCR));
            rdy = tgt ? s1_ar_ready : s0_ar_ready;
            check_val("m1_ar_ready", 32'(m1_ar_ready), 32'(exp_m1 & rdy));
            check_val("m0_ar_ready", 32'(m0_ar_ready), 32'(!exp_m1 & rdy));
            lock0 = !exp_m1 && !rdy;
            lock1 = exp_m1 && !rdy;
            if (rdy) begin
                slave_q[tgt].push_back(b);
                wait_cnt[tgt] = 0;
                if (exp_m1) m1_act = 1'b0;
                else m0_act = 1'b0;
            end else begin
                wait_cnt[tgt]++;
            end
        end
    endtask

    // Expected R source from the slave 1 first, whole burst rule
    task automatic check_r();
        logic have, src, to_m1, exp_last, hs;
        burst_t b;
        have = 1'b1;
        src = 1'b0;
        if (own_v) src = own;
        else if (rv[1]) src = 1'b1;
        else if (rv[0]) src = 1'b0;
        else have = 1'b0;
        hs = 1'b0;
        exp_last = 1'b0;
        if (have && rv[src]) begin
            b = slave_q[src][0];
            to_m1 = (b.id[IDS_BITS-1:ID_BITS] == TAG_M1);
            exp_last = (beat[src] == b.len);
            check_val("m1_r_valid", 32'(m1_r_valid), 32'(to_m1));
            check_val("m0_r_valid", 32'(m0_r_valid), 32'(!to_m1));
            check_val("r_id", 32'(to_m1 ? m1_r_id : m0_r_id), 32'(b.id[ID_BITS-1:0]));
            check_val("r_data", to_m1 ? m1_r_data : m0_r_data, b.addr + {28'd0, beat[src]});
            check_val("r_last", 32'(to_m1 ? m1_r_last : m0_r_last), 32'(exp_last));
            check_val("r_resp", 32'(to_m1 ? m1_r_resp : m0_r_resp), 32'(RESP_OKAY));
            hs = to_m1 ? m1_r_ready : m0_r_ready;
            check_val("s1_r_ready", 32'(s1_r_ready), 32'(src & hs));
            check_val("s0_r_ready", 32'(s0_r_ready), 32'(!src & hs));
        end else begin
            check_val("m0_r_valid", 32'(m0_r_valid), 32'd0);
            check_val("m1_r_valid", 32'(m1_r_valid), 32'd0);
            check_val("s0_r_ready", 32'(s0_r_ready), 32'd0);
            check_val("s1_r_ready", 32'(s1_r_ready), 32'd0);
        end
        if (hs) begin
            rv[src] = 1'b0;
            if (exp_last) begin
                void'(slave_q[src].pop_front());
                beat[src] = '0;
                own_v = 1'b0;
            end else begin
                beat[src] = beat[src] + 4'd1;
                own_v = 1'b1;
                own = src;
            end
        end else if (!own_v && have) begin
            own_v = 1'b1;
            own = src;
        end
    endtask

    initial begin
        int cyc;
        void'($urandom(37403));
        stim[0] = make_row(1, 4'h3, 32'h0000_0100, 4'd1, 1, 4'h5, 32'h0000_0200, 4'd2,
                           0, 0, 0, 0, 0);
        stim[1] = make_row(1, 4'h7, 32'h0000_0040, 4'd0, 1, 4'h9, 32'h0000_0080, 4'd1,
                           2, 4, 0, 0, 0);
        stim[2] = make_row(1, 4'hA, 32'h0001_0000, 4'd3, 1, 4'h2, 32'h0000_1000, 4'd3,
                           0, 1, 2, 1, 0);
        stim[3] = make_row(1, 4'h1, 32'h0000_0010, 4'd7, 1, 4'h4, 32'h0003_0000, 4'd7,
                           0, 0, 0, 0, 1);
        stim[4] = make_row(1, 4'hC, 32'hABCD_0000, 4'd15, 0, 4'h0, 32'h0, 4'd0,
                           0, 0, 2, 1, 0);
        stim[5] = make_row(0, 4'h0, 32'h0, 4'd0, 1, 4'hF, 32'h0000_FFF0, 4'd0,
                           0, MAX_DELAY, 0, 0, 0);
        rst = 1'b0;
        m0_act = 1'b0;
        m1_act = 1'b0;
        lock0 = 1'b0;
        lock1 = 1'b0;
        own_v = 1'b0;
        own = 1'b0;
        rv = '{1'b0, 1'b0};
        beat = '{4'd0, 4'd0};
        wait_cnt = '{0, 0};
        m0_ar_size = 3'd2;
        m1_ar_size = 3'd1;
        m0_ar_burst = BURST_INCR;
        m1_ar_burst = BURST_INCR;
        drive_inputs(0);
        m0_r_ready = 1'b0;
        m1_r_ready = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b1;
        @(negedge clk);
        check_r();                     // Idle after reset
        check_ar(0);
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1;
            cyc = 0;
            m0_act = stim[r].m0_v;
            m1_todo = stim[r].m1_v && (stim[r].m1_start > 0);
            m1_act = stim[r].m1_v && (stim[r].m1_start == 0);
            wait_cnt = '{0, 0};
            drive_inputs(r);
            while (m0_act || m1_act || m1_todo || rv[0] || rv[1] ||
                   slave_q[0].size() > 0 || slave_q[1].size() > 0) begin
                @(negedge clk);
                check_ar(r);
                check_r();
                @(posedge clk);
                #1;
                cyc++;
                if (m1_todo && cyc == stim[r].m1_start) begin
                    m1_act = 1'b1;
                    m1_todo = 1'b0;
                end
                drive_inputs(r);
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
